/* burst_writer/burst_writer.sv */
// single burst address and data sequencer
`default_nettype none
`timescale 1ns/100ps

`include "mult_wr_cfg.svh"

module burst_writer (
    input  wire                           aclk,
    input  wire                           mclk,
    input  wire                           grant_i,   // start one burst
    input  wire [`MW_CHN_BITS-1:0]        chn_i,
    input  mem_bus_pkg::aw_req_t          aw_i,      // address for chn_i
    input  chn_ctrl_pkg::src_in_t         src_i [`MW_NUM_CHN],
    output logic [`MW_NUM_CHN-1:0]        src_pop_o, // one per accepted beat
    output mem_bus_pkg::aw_req_t          aw_o,
    output logic                          awvalid_o,
    input  wire                           awready_i,
    output mem_bus_pkg::w_beat_t          w_o,
    output logic                          wvalid_o,
    input  wire                           wready_i,
    output logic                          done_o     // single cycle
);

    localparam int CNT_W = $clog2(`MW_BURST_WORDS);

    logic [`MW_CHN_BITS-1:0] chn_q;     // granted source
    mem_bus_pkg::aw_req_t    aw_q;      // latched request
    logic [CNT_W-1:0]        beat_cnt;  // accepted beats so far
    logic                    busy;      // burst in flight
    logic                    w_fire;
    logic                    last_beat;
    logic                    aw_left;   // address still pending next cycle
    logic                    w_left;    // data still pending next cycle

    assign w_fire    = wvalid_o & wready_i;
    assign last_beat = (beat_cnt == CNT_W'(`MW_BURST_WORDS - 1));
    assign aw_left   = awvalid_o & ~awready_i;
    assign w_left    = wvalid_o & ~(wready_i & last_beat);

    assign aw_o      = aw_q;
    assign w_o.data  = src_i[chn_q].data;   // fall-through front word
    assign w_o.last  = last_beat;

    always_comb begin
        src_pop_o = '0;
        if (w_fire)
            src_pop_o[chn_q] = 1'b1;        // next word shows next cycle
    end

    always_ff @(posedge aclk) begin
        if (grant_i)
            aw_q <= aw_i;
    end

    always_ff @(posedge aclk or posedge mclk) begin
        if (mclk) begin
            chn_q     <= '0;
            awvalid_o <= 1'b0;
            wvalid_o  <= 1'b0;
            beat_cnt  <= '0;
            busy      <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (grant_i) begin
                chn_q     <= chn_i;
                awvalid_o <= 1'b1;
                wvalid_o  <= 1'b1;
                beat_cnt  <= '0;
                busy      <= 1'b1;
            end else begin
                if (awvalid_o && awready_i)
                    awvalid_o <= 1'b0;      // address phase over
                if (w_fire) begin
                    beat_cnt <= beat_cnt + 1'b1;
                    if (last_beat)
                        wvalid_o <= 1'b0;   // data phase over
                end
                if (busy && !aw_left && !w_left) begin
                    busy   <= 1'b0;
                    done_o <= 1'b1;         // both phases finished
                end
            end
        end
    end

endmodule

`default_nettype wire

/* common/chn_ctrl_pkg.sv */
// source and channel control types
`default_nettype none

`include "mult_wr_cfg.svh"

package chn_ctrl_pkg;

    // front of one fall-through source fifo
    typedef struct packed {
        logic                  has_burst; // a full burst is waiting
        logic [`MW_DATA_W-1:0] data;      // front word
    } src_in_t;

    // circular region of one channel, in words
    typedef struct packed {
        logic [`MW_WADDR_W-1:0] start;
        logic [`MW_WADDR_W-1:0] len;
    } chn_cfg_t;

    // mode register layout
    typedef struct packed {
        logic [`MW_NUM_CHN-1:0] run; // arbitration allowed
        logic [`MW_NUM_CHN-1:0] en;  // channel on, off clears pointer
    } mode_t;

endpackage

`default_nettype wire

/* common/mem_bus_pkg.sv */
// memory write port channel types
`default_nettype none

`include "mult_wr_cfg.svh"

package mem_bus_pkg;

    // write address request, one per burst
    typedef struct packed {
        logic [`MW_WADDR_W+1:0]              addr; // byte address
        logic [$clog2(`MW_BURST_WORDS)-1:0]  len;  // beats minus one
        logic [1:0]                          size; // fixed, 4 bytes
        logic [1:0]                          burst;// fixed, incr
        logic [`MW_CHN_BITS-1:0]             id;   // source channel
    } aw_req_t;

    // one write data beat
    typedef struct packed {
        logic [`MW_DATA_W-1:0] data;
        logic                  last; // final beat of burst
    } w_beat_t;

endpackage

`default_nettype wire

/* common/mult_wr_cfg.svh */
// burst collector configuration
`ifndef MULT_WR_CFG_SVH
`define MULT_WR_CFG_SVH

// channel set
`define MW_NUM_CHN        4     // number of sources
`define MW_CHN_BITS       2     // channel index width

// burst and data geometry
`define MW_BURST_WORDS    16    // fixed burst, all channels
`define MW_DATA_W         32    // data word width
`define MW_WADDR_W        30    // word address width

// apb register map
`define MW_PADDR_W        8     // apb address width
`define MW_REG_MODE       8'h00 // {run[3:0], en[3:0]}
`define MW_REG_CHN_BASE   8'h10 // start, length per channel
`define MW_REG_PNTR_BASE  8'h40 // pointer read-back per channel

// fixed write attributes
`define MW_AW_SIZE        2'h2  // 4 bytes per beat
`define MW_AW_BURST       2'h1  // incrementing

`endif

/* filelist.f */
+incdir+common
common/mem_bus_pkg.sv
common/chn_ctrl_pkg.sv
hdl/chn_regs.sv
hdl/round_robin_arb.sv
hdl/chn_pointers.sv
burst_writer/burst_writer.sv
hdl/mult_saxi_wr_top.sv
testbench/wr_checker.sv
testbench/tb_mult_saxi_wr.sv

/* hdl/chn_pointers.sv */
// circular write pointers per channel
`default_nettype none
`timescale 1ns/100ps

`include "mult_wr_cfg.svh"

module chn_pointers (
    input  wire                            aclk,
    input  wire                            mclk,
    input  chn_ctrl_pkg::chn_cfg_t         cfg_i [`MW_NUM_CHN],
    input  wire [`MW_NUM_CHN-1:0]          en_i,
    input  wire [`MW_NUM_CHN-1:0]          cfg_wr_i,
    input  wire [`MW_CHN_BITS-1:0]         chn_i,   // granted channel
    input  wire                            done_i,  // advance chn_i pointer
    output mem_bus_pkg::aw_req_t           aw_o,
    output logic [`MW_WADDR_W-1:0]         pntr_o [`MW_NUM_CHN]
);

    logic [`MW_WADDR_W-1:0] word_addr;  // start plus pointer
    logic [`MW_WADDR_W-1:0] pntr_inc;   // pointer one burst on
    logic [`MW_WADDR_W-1:0] pntr_next;  // after wrap

    assign word_addr = cfg_i[chn_i].start + pntr_o[chn_i];
    assign pntr_inc  = pntr_o[chn_i] + `MW_WADDR_W'(`MW_BURST_WORDS);
    assign pntr_next = (pntr_inc >= cfg_i[chn_i].len) ? '0 : pntr_inc; // wrap at length

    always_comb begin
        aw_o       = '0;
        aw_o.addr  = {word_addr, 2'b00};   // bytes
        aw_o.len   = $bits(aw_o.len)'(`MW_BURST_WORDS - 1);
        aw_o.size  = `MW_AW_SIZE;
        aw_o.burst = `MW_AW_BURST;
        aw_o.id    = chn_i;                // id is the channel
    end

    always_ff @(posedge aclk or posedge mclk) begin
        if (mclk) begin
            for (int k = 0; k < `MW_NUM_CHN; k++)
                pntr_o[k] <= '0;
        end else begin
            for (int k = 0; k < `MW_NUM_CHN; k++) begin
                if (!en_i[k] || cfg_wr_i[k])
                    pntr_o[k] <= '0;                  // restart region
                else if (done_i && (chn_i == `MW_CHN_BITS'(k)))
                    pntr_o[k] <= pntr_next;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/chn_regs.sv */
// apb control and status registers
`default_nettype none
`timescale 1ns/100ps

`include "mult_wr_cfg.svh"

module chn_regs (
    input  wire                            aclk,
    input  wire                            mclk,
    input  wire                            psel_i,
    input  wire                            penable_i,
    input  wire                            pwrite_i,
    input  wire [`MW_PADDR_W-1:0]          paddr_i,
    input  wire [31:0]                     pwdata_i,
    output logic [31:0]                    prdata_o,
    output logic                           pready_o,
    output logic                           pslverr_o,
    input  wire [`MW_WADDR_W-1:0]          pntr_i [`MW_NUM_CHN],
    output chn_ctrl_pkg::mode_t            mode_o,
    output chn_ctrl_pkg::chn_cfg_t         cfg_o [`MW_NUM_CHN],
    output logic [`MW_NUM_CHN-1:0]         cfg_wr_o
);

    logic                    acc;       // apb access phase
    logic                    wr_acc;
    logic                    aligned;
    logic [`MW_PADDR_W-1:0]  chn_off;   // offset into channel block
    logic [`MW_PADDR_W-1:0]  pntr_off;  // offset into pointer block
    logic                    hit_mode;
    logic                    hit_chn;
    logic                    hit_pntr;
    logic [`MW_CHN_BITS-1:0] chn_idx;
    logic [`MW_CHN_BITS-1:0] pntr_idx;

    assign pready_o = 1'b1;             // no wait states
    assign acc      = psel_i & penable_i;
    assign wr_acc   = acc & pwrite_i;
    assign aligned  = (paddr_i[1:0] == 2'b00);

    // below-base addresses wrap high and miss
    assign chn_off  = paddr_i - `MW_REG_CHN_BASE;
    assign pntr_off = paddr_i - `MW_REG_PNTR_BASE;
    assign hit_mode = aligned && (paddr_i == `MW_REG_MODE);
    assign hit_chn  = aligned && (chn_off < `MW_PADDR_W'(8 * `MW_NUM_CHN));
    assign hit_pntr = aligned && (pntr_off < `MW_PADDR_W'(4 * `MW_NUM_CHN));
    assign chn_idx  = chn_off[3 +: `MW_CHN_BITS];   // 8 bytes per channel
    assign pntr_idx = pntr_off[2 +: `MW_CHN_BITS];  // 4 bytes per channel

    // unmapped, or a write to read-only pointers
    assign pslverr_o = acc & ~(hit_mode | hit_chn | (hit_pntr & ~pwrite_i));

    always_comb begin
        cfg_wr_o = '0;
        if (wr_acc && hit_chn)
            cfg_wr_o[chn_idx] = 1'b1;   // pointer restarts
    end

    always_ff @(posedge aclk or posedge mclk) begin
        if (mclk) begin
            mode_o <= '0;
            for (int k = 0; k < `MW_NUM_CHN; k++)
                cfg_o[k] <= '0;
        end else if (wr_acc) begin
            if (hit_mode)
                mode_o <= chn_ctrl_pkg::mode_t'(pwdata_i[$bits(mode_o)-1:0]);
            if (hit_chn && chn_off[2])
                cfg_o[chn_idx].len   <= pwdata_i[`MW_WADDR_W-1:0]; // second word
            else if (hit_chn)
                cfg_o[chn_idx].start <= pwdata_i[`MW_WADDR_W-1:0];
        end
    end

    always_comb begin
        prdata_o = '0;
        if (hit_mode)
            prdata_o[$bits(mode_o)-1:0] = mode_o;
        else if (hit_chn && chn_off[2])
            prdata_o[`MW_WADDR_W-1:0] = cfg_o[chn_idx].len;
        else if (hit_chn)
            prdata_o[`MW_WADDR_W-1:0] = cfg_o[chn_idx].start;
        else if (hit_pntr)
            prdata_o[`MW_WADDR_W-1:0] = pntr_i[pntr_idx]; // words, not bytes
    end

endmodule

`default_nettype wire

/* hdl/mult_saxi_wr_top.sv */
// four channel burst write collector
`default_nettype none
`timescale 1ns/100ps

`include "mult_wr_cfg.svh"

module mult_saxi_wr_top (
    input  wire                           aclk,
    input  wire                           mclk,       // async reset
    // apb
    input  wire                           psel_i,
    input  wire                           penable_i,
    input  wire                           pwrite_i,
    input  wire [`MW_PADDR_W-1:0]         paddr_i,
    input  wire [31:0]                    pwdata_i,
    output logic [31:0]                   prdata_o,
    output logic                          pready_o,
    output logic                          pslverr_o,
    // sources
    input  chn_ctrl_pkg::src_in_t         src_i [`MW_NUM_CHN],
    output logic [`MW_NUM_CHN-1:0]        src_pop_o,
    output logic [`MW_NUM_CHN-1:0]        src_en_o,
    // memory write port
    output mem_bus_pkg::aw_req_t          aw_o,
    output logic                          awvalid_o,
    input  wire                           awready_i,
    output mem_bus_pkg::w_beat_t          w_o,
    output logic                          wvalid_o,
    input  wire                           wready_i
);

    chn_ctrl_pkg::mode_t    mode;                    // en / run nibbles
    chn_ctrl_pkg::chn_cfg_t cfg [`MW_NUM_CHN];       // start, length
    logic [`MW_NUM_CHN-1:0] cfg_wr;                  // start/len written
    logic [`MW_WADDR_W-1:0] pntr [`MW_NUM_CHN];      // running pointers
    logic [`MW_NUM_CHN-1:0] rq;                      // arbiter requests
    logic                   grant;                   // one cycle
    logic [`MW_CHN_BITS-1:0] grant_chn;
    logic                   burst_done;
    mem_bus_pkg::aw_req_t   aw_next;                 // address of granted chn

    assign src_en_o = mode.en;

    for (genvar k = 0; k < `MW_NUM_CHN; k++) begin : g_rq
        assign rq[k] = src_i[k].has_burst & mode.en[k] & mode.run[k];
    end

    chn_regs i_regs (
        .aclk      (aclk),
        .mclk      (mclk),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .pntr_i    (pntr),
        .mode_o    (mode),
        .cfg_o     (cfg),
        .cfg_wr_o  (cfg_wr)
    );

    round_robin_arb i_arb (
        .aclk    (aclk),
        .mclk    (mclk),
        .rq_i    (rq),
        .done_i  (burst_done),
        .grant_o (grant),
        .chn_o   (grant_chn)
    );

    chn_pointers i_pntr (
        .aclk     (aclk),
        .mclk     (mclk),
        .cfg_i    (cfg),
        .en_i     (mode.en),
        .cfg_wr_i (cfg_wr),
        .chn_i    (grant_chn),
        .done_i   (burst_done),
        .aw_o     (aw_next),
        .pntr_o   (pntr)
    );

    burst_writer i_writer (
        .aclk      (aclk),
        .mclk      (mclk),
        .grant_i   (grant),
        .chn_i     (grant_chn),
        .aw_i      (aw_next),
        .src_i     (src_i),
        .src_pop_o (src_pop_o),
        .aw_o      (aw_o),
        .awvalid_o (awvalid_o),
        .awready_i (awready_i),
        .w_o       (w_o),
        .wvalid_o  (wvalid_o),
        .wready_i  (wready_i),
        .done_o    (burst_done)
    );

endmodule

`default_nettype wire

/* hdl/round_robin_arb.sv */
// round-robin channel arbiter
`default_nettype none
`timescale 1ns/100ps

`include "mult_wr_cfg.svh"

module round_robin_arb (
    input  wire                           aclk,
    input  wire                           mclk,
    input  wire [`MW_NUM_CHN-1:0]         rq_i,    // channel wants a burst
    input  wire                           done_i,  // burst finished, re-arm
    output logic                          grant_o, // single cycle
    output logic [`MW_CHN_BITS-1:0]       chn_o    // held until next grant
);

    logic                    armed;    // may issue a grant
    logic [`MW_CHN_BITS-1:0] last_q;   // last served channel
    logic [`MW_CHN_BITS-1:0] idx;
    logic [`MW_CHN_BITS-1:0] pick;

    // scan from last+NUM down to last+1 so last+1 wins
    always_comb begin
        pick = last_q;
        idx  = last_q;
        for (int i = `MW_NUM_CHN; i >= 1; i--) begin
            idx = last_q + `MW_CHN_BITS'(i);
            if (rq_i[idx])
                pick = idx;
        end
    end

    always_ff @(posedge aclk or posedge mclk) begin
        if (mclk) begin
            armed   <= 1'b1;
            last_q  <= `MW_CHN_BITS'(`MW_NUM_CHN - 1); // channel 0 goes first
            chn_o   <= '0;
            grant_o <= 1'b0;
        end else begin
            grant_o <= 1'b0;
            if (done_i) begin
                armed <= 1'b1;          // one burst in flight at most
            end else if (armed && |rq_i) begin
                armed   <= 1'b0;
                grant_o <= 1'b1;
                chn_o   <= pick;
                last_q  <= pick;        // rotates priority
            end
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f filelist.f \
    --top-module tb_mult_saxi_wr -Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1
grep -q "Finished with no errors" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

/* testbench/tb_mult_saxi_wr.sv */
// burst collector testbench
`default_nettype none
`timescale 1ns/100ps

`include "mult_wr_cfg.svh"

module tb_mult_saxi_wr;

    localparam int OP_WR   = 0;
    localparam int OP_RD   = 1;
    localparam int OP_WAIT = 2;     // data holds burst count
    localparam int OP_IDLE = 3;     // write port quiet
    localparam int ROW_CYC = 2400;  // bound for the longest row of 12 bursts

    typedef struct packed {
        logic [1:0]  op;
        logic [7:0]  addr;
        logic [31:0] data;
        logic [31:0] exp;
        logic        err;
        logic        model;
    } row_t;

    logic                   aclk;
    logic                   mclk;
    logic                   psel_i;
    logic                   penable_i;
    logic                   pwrite_i;
    logic [`MW_PADDR_W-1:0] paddr_i;
    logic [31:0]            pwdata_i;
    logic [31:0]            prdata_o;
    logic                   pready_o;
    logic                   pslverr_o;
    chn_ctrl_pkg::src_in_t  src_i [`MW_NUM_CHN];
    logic [`MW_NUM_CHN-1:0] src_pop_o;
    logic [`MW_NUM_CHN-1:0] src_en_o;
    mem_bus_pkg::aw_req_t   aw_o;
    logic                   awvalid_o;
    logic                   awready_i = 1'b0;
    mem_bus_pkg::w_beat_t   w_o;
    logic                   wvalid_o;
    logic                   wready_i = 1'b0;
    logic [31:0]            exp_data;
    logic                   exp_err;
    logic                   exp_chk;
    logic                   exp_model;
    logic [23:0]            cnt [`MW_NUM_CHN];   // source running counts
    logic [31:0]            rnd_state = 32'd58530;
    row_t                   tbl [$];

    mult_saxi_wr_top i_dut (
        .aclk(aclk), .mclk(mclk),
        .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
        .pready_o(pready_o), .pslverr_o(pslverr_o),
        .src_i(src_i), .src_pop_o(src_pop_o), .src_en_o(src_en_o),
        .aw_o(aw_o), .awvalid_o(awvalid_o), .awready_i(awready_i),
        .w_o(w_o), .wvalid_o(wvalid_o), .wready_i(wready_i)
    );

    wr_checker i_chk (
        .aclk(aclk), .mclk(mclk),
        .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_i(prdata_o),
        .pready_i(pready_o), .pslverr_i(pslverr_o),
        .exp_data_i(exp_data), .exp_err_i(exp_err),
        .exp_chk_i(exp_chk), .exp_model_i(exp_model), .src_en_i(src_en_o),
        .src_pop_i(src_pop_o),
        .aw_i(aw_o), .awvalid_i(awvalid_o), .awready_i(awready_i),
        .w_i(w_o), .wvalid_i(wvalid_o), .wready_i(wready_i)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    // fall-through sources that always hold a burst
    always @(posedge aclk) begin : src_model
        logic [`MW_NUM_CHN-1:0] pop;
        pop = src_pop_o;
        #2;
        for (int k = 0; k < `MW_NUM_CHN; k++) begin
            if (pop[k])
                cnt[k] = cnt[k] + 1'b1;
            src_i[k].data = {8'(k), cnt[k]};
        end
    end

    // memory with random ready
    always @(posedge aclk) begin
        #2;
        rnd_state = xorshift(rnd_state);
        awready_i = (rnd_state[1:0] != 2'b00);
        wready_i  = (rnd_state[9:8] != 2'b00);
    end

    task automatic add_row(input int op, input logic [7:0] addr, input logic [31:0] data,
                           input logic [31:0] exp, input logic err, input logic model);
        row_t r;
        r.op    = 2'(op);
        r.addr  = addr;
        r.data  = data;
        r.exp   = exp;
        r.err   = err;
        r.model = model;
        tbl.push_back(r);
    endtask

    task automatic load_table();
        add_row(OP_RD, 8'h00, 0, 32'h0, 0, 0);          // mode after reset
        add_row(OP_WR, 8'h10, 32'h1000, 0, 0, 0);
        add_row(OP_WR, 8'h14, 64, 0, 0, 0);
        add_row(OP_WR, 8'h18, 32'h2000, 0, 0, 0);
        add_row(OP_WR, 8'h1c, 48, 0, 0, 0);
        add_row(OP_WR, 8'h20, 32'h3000, 0, 0, 0);
        add_row(OP_WR, 8'h24, 32, 0, 0, 0);
        add_row(OP_WR, 8'h28, 32'h4000, 0, 0, 0);
        add_row(OP_WR, 8'h2c, 64, 0, 0, 0);
        add_row(OP_RD, 8'h10, 0, 32'h1000, 0, 0);
        add_row(OP_RD, 8'h14, 0, 64, 0, 0);
        add_row(OP_RD, 8'h24, 0, 32, 0, 0);
        add_row(OP_RD, 8'h2c, 0, 64, 0, 0);
        add_row(OP_WR, 8'h08, 32'hff, 0, 1, 0);        // hole in map
        add_row(OP_RD, 8'h30, 0, 0, 1, 0);
        add_row(OP_WR, 8'h40, 32'h10, 0, 1, 0);        // pointer is read-only
        add_row(OP_RD, 8'h06, 0, 0, 1, 0);             // misaligned
        add_row(OP_RD, 8'h00, 0, 32'h0, 0, 0);
        add_row(OP_WR, 8'h00, 32'h11, 0, 0, 0);        // channel 0 only
        add_row(OP_RD, 8'h00, 0, 32'h11, 0, 0);
        add_row(OP_WAIT, 8'h00, 6, 0, 0, 0);           // wraps after 4
        add_row(OP_WR, 8'h00, 32'h01, 0, 0, 0);
        add_row(OP_IDLE, 8'h00, 0, 0, 0, 0);
        add_row(OP_RD, 8'h40, 0, 0, 0, 1);
        add_row(OP_WR, 8'h00, 32'hff, 0, 0, 0);        // all four rotate
        add_row(OP_WAIT, 8'h00, 12, 0, 0, 0);
        add_row(OP_WR, 8'h00, 32'h0f, 0, 0, 0);
        add_row(OP_IDLE, 8'h00, 0, 0, 0, 0);
        for (int k = 0; k < `MW_NUM_CHN; k++)
            add_row(OP_RD, 8'(8'h40 + 4 * k), 0, 0, 0, 1);
        add_row(OP_WR, 8'h00, 32'h0e, 0, 0, 0);        // channel 0 off
        add_row(OP_RD, 8'h40, 0, 0, 0, 1);
        add_row(OP_WR, 8'h18, 32'h2100, 0, 0, 0);      // restarts channel 1
        add_row(OP_RD, 8'h44, 0, 0, 0, 1);
        add_row(OP_WR, 8'h00, 32'hee, 0, 0, 0);
        add_row(OP_WAIT, 8'h00, 6, 0, 0, 0);
        add_row(OP_WR, 8'h00, 32'h0e, 0, 0, 0);
        add_row(OP_IDLE, 8'h00, 0, 0, 0, 0);
        for (int k = 0; k < `MW_NUM_CHN; k++)
            add_row(OP_RD, 8'(8'h40 + 4 * k), 0, 0, 0, 1);
    endtask

    task automatic apb_xfer(input row_t r);
        @(posedge aclk);
        #2;
        psel_i    = 1'b1;                               // setup
        penable_i = 1'b0;
        pwrite_i  = (r.op == OP_WR);
        paddr_i   = r.addr;
        pwdata_i  = r.data;
        exp_data  = r.exp;
        exp_err   = r.err;
        exp_model = r.model;
        exp_chk   = (r.op == OP_RD);
        @(posedge aclk);
        #2;
        penable_i = 1'b1;                               // access
        @(posedge aclk);
        #2;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        exp_chk   = 1'b0;
    endtask

    task automatic wait_bursts(input int n);
        int target;
        int waited;
        target = i_chk.bursts + n;
        waited = 0;
        while (i_chk.bursts < target && waited < n * 200) begin
            @(posedge aclk);
            waited++;
        end
        if (i_chk.bursts < target)
            i_chk.report_miss($sformatf("only %0d of %0d bursts arrived",
                                        n - (target - i_chk.bursts), n));
    endtask

    task automatic wait_idle();
        int quiet;
        int waited;
        quiet  = 0;
        waited = 0;
        while (quiet < 4 && waited < 400) begin
            @(posedge aclk);
            quiet = (awvalid_o || wvalid_o) ? 0 : quiet + 1;
            waited++;
        end
        if (quiet < 4)
            i_chk.report_miss("write port never went idle");
    endtask

    initial begin : main
        row_t r;
        load_table();
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        exp_data  = '0;
        exp_err   = 1'b0;
        exp_chk   = 1'b0;
        exp_model = 1'b0;
        for (int k = 0; k < `MW_NUM_CHN; k++) begin
            cnt[k]             = '0;
            src_i[k].has_burst = 1'b1;
            src_i[k].data      = {8'(k), 24'h0};
        end
        mclk = 1'b1;
        repeat (2) @(posedge aclk);
        #2;
        mclk = 1'b0;
        foreach (tbl[i]) begin
            r = tbl[i];
            case (r.op)
                OP_WAIT: wait_bursts(int'(r.data));
                OP_IDLE: wait_idle();
                default: apb_xfer(r);
            endcase
        end
        repeat (4) @(posedge aclk);
        i_chk.final_report();
        if (i_chk.errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    initial begin : watchdog
        #1;
        repeat (tbl.size() * ROW_CYC) @(posedge aclk);
        $display("watchdog expired before the stimulus table finished");
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/wr_checker.sv */
// write port and register checker
`default_nettype none
`timescale 1ns/100ps

`include "mult_wr_cfg.svh"

module wr_checker (
    input  wire                           aclk,
    input  wire                           mclk,
    input  wire                           psel_i,
    input  wire                           penable_i,
    input  wire                           pwrite_i,
    input  wire [`MW_PADDR_W-1:0]         paddr_i,
    input  wire [31:0]                    pwdata_i,
    input  wire [31:0]                    prdata_i,
    input  wire                           pready_i,
    input  wire                           pslverr_i,
    input  wire [31:0]                    exp_data_i,  // table read value
    input  wire                           exp_err_i,
    input  wire                           exp_chk_i,   // compare read data
    input  wire                           exp_model_i, // pointer from model
    input  wire [`MW_NUM_CHN-1:0]         src_en_i,
    input  wire [`MW_NUM_CHN-1:0]         src_pop_i,
    input  mem_bus_pkg::aw_req_t          aw_i,
    input  wire                           awvalid_i,
    input  wire                           awready_i,
    input  mem_bus_pkg::w_beat_t          w_i,
    input  wire                           wvalid_i,
    input  wire                           wready_i
);

    int          errors;
    int          bursts;              // completed data bursts
    int          words;
    int          aw_cnt;              // accepted addresses
    int          mode_age;            // cycles since mode write
    logic [31:0] start_m [`MW_NUM_CHN];
    logic [31:0] len_m [`MW_NUM_CHN];
    logic [31:0] pntr_m [`MW_NUM_CHN]; // predicted pointers in words
    logic [23:0] nxt [`MW_NUM_CHN];    // next count per source
    logic [7:0]  mode_m;
    logic [4:0]  bc;                  // beat in burst
    logic        aw_q;                // awvalid last cycle
    logic        rot_ok;
    logic [1:0]  last_id;

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, got %h", name, exp_v, act_v);
        end
    endtask

    task automatic report_miss(input string what);
        errors++;
        $display("ERROR: %s", what);
    endtask

    task automatic final_report();
        if (words != 16 * bursts || aw_cnt != bursts)
            report_miss($sformatf("%0d addresses and %0d words do not make %0d whole bursts",
                                  aw_cnt, words, bursts));
        $display("bursts %0d, words %0d, errors %0d", bursts, words, errors);
    endtask

    always @(posedge aclk or posedge mclk) begin : watch
        int                     id;
        int                     ch;
        logic [31:0]            exp_addr;
        logic [`MW_NUM_CHN-1:0] exp_pop;
        if (mclk) begin
            errors   = 0;
            bursts   = 0;
            words    = 0;
            aw_cnt   = 0;
            mode_age = 0;
            mode_m   = '0;
            bc       = '0;
            aw_q     = 1'b0;
            rot_ok   = 1'b0;
            last_id  = 2'd3;
            for (int k = 0; k < `MW_NUM_CHN; k++) begin
                start_m[k] = '0;
                len_m[k]   = '0;
                pntr_m[k]  = '0;
                nxt[k]     = '0;
            end
        end else begin
            if (mode_age < 1000)
                mode_age++;
            check_val("src_en_o", 32'(mode_m[3:0]), 32'(src_en_i));
            if (psel_i && penable_i) begin              // access cycle
                check_val("pready_o", 32'h1, 32'(pready_i));
                check_val("pslverr_o", 32'(exp_err_i), 32'(pslverr_i));
                if (exp_chk_i && !exp_err_i)
                    check_val("prdata_o", exp_model_i ? pntr_m[paddr_i[3:2]] : exp_data_i,
                              prdata_i);
                if (pwrite_i && !exp_err_i) begin
                    if (paddr_i == `MW_REG_MODE) begin
                        mode_m   = pwdata_i[7:0];
                        mode_age = 0;
                        rot_ok   = 1'b0;
                        for (int k = 0; k < `MW_NUM_CHN; k++)
                            if (!pwdata_i[k])
                                pntr_m[k] = '0;         // disabled channel restarts
                    end else begin
                        ch = (paddr_i - `MW_REG_CHN_BASE) >> 3;
                        if (paddr_i[2])
                            len_m[ch] = pwdata_i;
                        else
                            start_m[ch] = pwdata_i;
                        pntr_m[ch] = '0;
                    end
                end
            end
            // request was sampled two cycles before awvalid rises
            if (awvalid_i && !aw_q && mode_age >= 3)
                if (!(mode_m[aw_i.id] && mode_m[4 + aw_i.id]))
                    report_miss($sformatf("burst granted to channel %0d, which may not run",
                                          aw_i.id));
            aw_q = awvalid_i;
            if (awvalid_i && awready_i) begin
                id       = aw_i.id;
                exp_addr = (start_m[id] + pntr_m[id]) << 2;
                check_val("aw_o.addr", exp_addr, 32'(aw_i.addr));
                check_val("aw_o.len", 32'(`MW_BURST_WORDS - 1), 32'(aw_i.len));
                check_val("aw_o.size", 32'h2, 32'(aw_i.size));    // 4-byte beats
                check_val("aw_o.burst", 32'h1, 32'(aw_i.burst));  // incrementing
                if (rot_ok && mode_m == 8'hff)
                    check_val("aw_o.id", 32'(2'(last_id + 2'd1)), 32'(id));
                last_id = 2'(id);
                rot_ok  = 1'b1;
                aw_cnt++;
                if (pntr_m[id] + 16 >= len_m[id])
                    pntr_m[id] = '0;                    // wrap at length
                else
                    pntr_m[id] = pntr_m[id] + 16;
            end
            exp_pop = '0;
            if (wvalid_i && wready_i)
                exp_pop[aw_i.id] = 1'b1;                // accepted beat pops its source
            check_val("src_pop_o", 32'(exp_pop), 32'(src_pop_i));
            if (wvalid_i && wready_i) begin
                id = aw_i.id;
                check_val("w_o.data", {8'(id), nxt[id]}, w_i.data);
                check_val("w_o.last", 32'(bc == 5'd15), 32'(w_i.last));
                nxt[id] = nxt[id] + 1'b1;
                words++;
                if (bc == 5'd15) begin
                    bc = '0;
                    bursts++;
                end else begin
                    bc = bc + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire
